/* hdl/cpu16_cfg.svh */
`ifndef CPU16_CFG_SVH
`define CPU16_CFG_SVH

// datapath word width
`define CPU16_WORD 16

// architectural registers
`define CPU16_NREG 4

// data memory words
// addresses wrap modulo this depth
`define CPU16_DMEM_DEPTH 256

`endif

/* hdl/cpu16Pkg.sv */
`include "cpu16_cfg.svh"

package cpu16Pkg;

    typedef logic [`CPU16_WORD-1:0] word_t;
    typedef logic [$clog2(`CPU16_NREG)-1:0] regIdx_t;
    typedef logic [3:0] opcode_t;
    typedef logic [5:0] func_t;
    typedef logic [1:0] aluOp_t;
    typedef logic [1:0] fwdSel_t;

    localparam opcode_t OpBne = 4'd0;
    localparam opcode_t OpBeq = 4'd1;
    localparam opcode_t OpAdi = 4'd4;
    localparam opcode_t OpLwd = 4'd7;
    localparam opcode_t OpSwd = 4'd8;
    localparam opcode_t OpJmp = 4'd9;
    localparam opcode_t OpR   = 4'd15;

    localparam func_t FnAdd = 6'd0;
    localparam func_t FnSub = 6'd1;
    localparam func_t FnAnd = 6'd2;
    localparam func_t FnOrr = 6'd3;
    localparam func_t FnWwd = 6'd28;
    localparam func_t FnHlt = 6'd29;

    localparam aluOp_t AluAdd = 2'd0;
    localparam aluOp_t AluSub = 2'd1;
    localparam aluOp_t AluAnd = 2'd2;
    localparam aluOp_t AluOr  = 2'd3;

    localparam fwdSel_t FwdReg = 2'd0;
    localparam fwdSel_t FwdMem = 2'd1;
    localparam fwdSel_t FwdWb  = 2'd2;

    localparam word_t InstrBubble = '1; // R-type with an unused func

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        aluOp_t aluOp;
        logic   isWwd;
        logic   isHlt;
        logic   valid;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifIdReg_t;

    typedef struct packed {
        ctrl_t   ctrl;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        word_t   opA;
        word_t   opB;
        word_t   imm;
    } idExReg_t;

    typedef struct packed {
        ctrl_t   ctrl;
        regIdx_t rd;
        word_t   aluRes;
        word_t   storeData;
    } exMemReg_t;

    typedef struct packed {
        ctrl_t   ctrl;
        regIdx_t rd;
        word_t   aluRes;
        word_t   loadData;
        word_t   wwdVal;
    } memWbReg_t;

endpackage

/* hdl/regFile.sv */
`timescale 1ns/1ns
`include "cpu16_cfg.svh"

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  cpu16Pkg::regIdx_t raddrA,
    input  cpu16Pkg::regIdx_t raddrB,
    output cpu16Pkg::word_t   rdataA,
    output cpu16Pkg::word_t   rdataB,
    input  cpu16Pkg::regIdx_t waddr,
    input  cpu16Pkg::word_t   wdata,
    input  logic              wen
);
    import cpu16Pkg::*;

    word_t regs [`CPU16_NREG];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU16_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through, a reader in decode sees the writeback value
    assign rdataA = (wen && waddr == raddrA) ? wdata : regs[raddrA];
    assign rdataB = (wen && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

/* hdl/decodeUnit.sv */
`timescale 1ns/1ns

module decodeUnit (
    input  cpu16Pkg::ifIdReg_t ifId,
    output cpu16Pkg::regIdx_t  rs,
    output cpu16Pkg::regIdx_t  rt,
    output cpu16Pkg::regIdx_t  rd,
    output cpu16Pkg::ctrl_t    ctrl,
    output cpu16Pkg::word_t    imm,
    output cpu16Pkg::word_t    target,
    output logic               isBranch,
    output logic               isBne,
    output logic               isJump
);
    import cpu16Pkg::*;

    opcode_t opcode;
    func_t   func;
    word_t   branchTarget;
    word_t   jumpTarget;

    assign opcode = ifId.instr[15:12];
    assign func   = ifId.instr[5:0];
    assign rs     = ifId.instr[11:10];
    assign rt     = ifId.instr[9:8];
    assign rd     = (opcode == OpR) ? ifId.instr[7:6] : rt; // ADI and LWD write rt
    assign imm    = word_t'($signed(ifId.instr[7:0]));

    assign branchTarget = ifId.pc + 1'b1 + imm;
    assign jumpTarget   = {ifId.pc[15:12], ifId.instr[11:0]};
    assign target       = isJump ? jumpTarget : branchTarget;

    always_comb begin
        ctrl     = '0;
        isBranch = 1'b0;
        isBne    = 1'b0;
        isJump   = 1'b0;
        case (opcode)
            OpR: begin
                ctrl.valid    = 1'b1;
                ctrl.regWrite = 1'b1;
                case (func)
                    FnAdd: ctrl.aluOp = AluAdd;
                    FnSub: ctrl.aluOp = AluSub;
                    FnAnd: ctrl.aluOp = AluAnd;
                    FnOrr: ctrl.aluOp = AluOr;
                    FnWwd: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.isWwd    = 1'b1;
                    end
                    FnHlt: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.isHlt    = 1'b1;
                    end
                    default: ctrl = '0; // bubbles land here
                endcase
            end
            OpAdi: begin
                ctrl.valid     = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OpLwd: begin
                ctrl.valid     = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OpSwd: begin
                ctrl.valid     = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OpBeq, OpBne: begin
                ctrl.valid = 1'b1;
                isBranch   = 1'b1;
                isBne      = (opcode == OpBne);
            end
            OpJmp: begin
                ctrl.valid = 1'b1;
                isJump     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit (
    input  cpu16Pkg::regIdx_t   idRs,
    input  cpu16Pkg::regIdx_t   idRt,
    input  logic                idUsesRt,
    input  logic                idIsBranch,
    input  cpu16Pkg::idExReg_t  idEx,
    input  cpu16Pkg::exMemReg_t exMem,
    input  cpu16Pkg::memWbReg_t memWb,
    output logic                stall,
    output cpu16Pkg::fwdSel_t   fwdA,
    output cpu16Pkg::fwdSel_t   fwdB
);
    import cpu16Pkg::*;

    logic loadUse;
    logic exBlocksBranch;
    logic memBlocksBranch;

    // load result only exists after the memory stage
    assign loadUse = idEx.ctrl.memRead &&
                     (idEx.rd == idRs || (idUsesRt && idEx.rd == idRt));

    // branches compare in decode with no forwarding
    assign exBlocksBranch  = idEx.ctrl.regWrite && (idEx.rd == idRs || idEx.rd == idRt);
    assign memBlocksBranch = exMem.ctrl.regWrite && (exMem.rd == idRs || exMem.rd == idRt);

    assign stall = loadUse || (idIsBranch && (exBlocksBranch || memBlocksBranch));

    always_comb begin
        fwdA = FwdReg;
        fwdB = FwdReg;
        if (exMem.ctrl.regWrite && exMem.rd == idEx.rs) begin
            fwdA = FwdMem; // younger result wins
        end else if (memWb.ctrl.regWrite && memWb.rd == idEx.rs) begin
            fwdA = FwdWb;
        end
        if (exMem.ctrl.regWrite && exMem.rd == idEx.rt) begin
            fwdB = FwdMem;
        end else if (memWb.ctrl.regWrite && memWb.rd == idEx.rt) begin
            fwdB = FwdWb;
        end
    end

endmodule

/* hdl/executeUnit.sv */
`timescale 1ns/1ns

module executeUnit (
    input  cpu16Pkg::idExReg_t idEx,
    input  cpu16Pkg::fwdSel_t  fwdA,
    input  cpu16Pkg::fwdSel_t  fwdB,
    input  cpu16Pkg::word_t    memFwd,
    input  cpu16Pkg::word_t    wbFwd,
    output cpu16Pkg::word_t    result,
    output cpu16Pkg::word_t    storeData
);
    import cpu16Pkg::*;

    word_t opA;
    word_t opB;
    word_t aluB;
    word_t aluOut;

    function automatic word_t fwdMux(
        input fwdSel_t sel,
        input word_t   regVal,
        input word_t   memVal,
        input word_t   wbVal
    );
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(fwdA, idEx.opA, memFwd, wbFwd);
    assign opB  = fwdMux(fwdB, idEx.opB, memFwd, wbFwd);
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            AluSub:  aluOut = opA - aluB;
            AluAnd:  aluOut = opA & aluB;
            AluOr:   aluOut = opA | aluB;
            default: aluOut = opA + aluB;
        endcase
    end

    // WWD rides to writeback in the result slot
    assign result    = idEx.ctrl.isWwd ? opA : aluOut;
    assign storeData = opB;

endmodule

/* hdl/dataRam.sv */
`timescale 1ns/1ns
`include "cpu16_cfg.svh"

module dataRam (
    input  logic            clk,
    input  cpu16Pkg::word_t addr,
    input  cpu16Pkg::word_t wdata,
    input  logic            wen,
    output cpu16Pkg::word_t rdata
);
    import cpu16Pkg::*;

    localparam int AddrBits = $clog2(`CPU16_DMEM_DEPTH);

    word_t               mem [`CPU16_DMEM_DEPTH];
    logic [AddrBits-1:0] index;

    assign index = addr[AddrBits-1:0]; // upper bits ignored, address wraps

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];

endmodule

/* hdl/pipeDatapath.sv */
`timescale 1ns/1ns

module pipeDatapath (
    input  logic            clk,
    input  logic            arstN,
    output cpu16Pkg::word_t imemAddr,
    output logic            imemRead,
    input  cpu16Pkg::word_t imemData,
    output cpu16Pkg::word_t dmemAddr,
    output cpu16Pkg::word_t dmemWData,
    output logic            dmemWrite,
    input  cpu16Pkg::word_t dmemRData,
    output cpu16Pkg::word_t outputPort,
    output logic            outputValid,
    output cpu16Pkg::word_t numInst,
    output logic            halted
);
    import cpu16Pkg::*;

    word_t     pc;
    ifIdReg_t  ifId;
    idExReg_t  idEx;
    exMemReg_t exMem;
    memWbReg_t memWb;

    regIdx_t decRs;
    regIdx_t decRt;
    regIdx_t decRd;
    ctrl_t   decCtrl;
    word_t   decImm;
    word_t   decTarget;
    logic    decIsBranch;
    logic    decIsBne;
    logic    decIsJump;
    word_t   rdataA;
    word_t   rdataB;
    logic    usesRt;
    logic    stall;
    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   exResult;
    word_t   exStoreData;
    word_t   wbData;
    logic    branchTaken;
    logic    redirect;
    logic    haltFreeze;
    logic    fetchStop;

    assign wbData = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluRes;

    regFile regFile_inst (
        .clk, .arstN,
        .raddrA(decRs), .raddrB(decRt), .rdataA, .rdataB,
        .waddr(memWb.rd), .wdata(wbData), .wen(memWb.ctrl.regWrite)
    );

    decodeUnit decodeUnit_inst (
        .ifId, .rs(decRs), .rt(decRt), .rd(decRd), .ctrl(decCtrl), .imm(decImm),
        .target(decTarget), .isBranch(decIsBranch), .isBne(decIsBne), .isJump(decIsJump)
    );

    // R-type ALU ops, stores and branches read rt
    assign usesRt = decCtrl.memWrite || decIsBranch ||
                    (decCtrl.regWrite && !decCtrl.aluSrcImm);

    hazardUnit hazardUnit_inst (
        .idRs(decRs), .idRt(decRt), .idUsesRt(usesRt), .idIsBranch(decIsBranch),
        .idEx, .exMem, .memWb, .stall, .fwdA, .fwdB
    );

    executeUnit executeUnit_inst (
        .idEx, .fwdA, .fwdB, .memFwd(exMem.aluRes), .wbFwd(wbData),
        .result(exResult), .storeData(exStoreData)
    );

    assign branchTaken = decIsBranch && ((rdataA == rdataB) != decIsBne);
    assign redirect    = !stall && (decIsJump || branchTaken);
    assign fetchStop   = haltFreeze || decCtrl.isHlt; // nothing younger than HLT

    assign imemAddr = pc;
    assign imemRead = !fetchStop;

    // fetch side, held as a unit by a stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= '0;
            ifId       <= '{pc: '0, instr: InstrBubble};
            haltFreeze <= 1'b0;
        end else if (!stall) begin
            if (decCtrl.isHlt) begin
                haltFreeze <= 1'b1;
            end
            if (!fetchStop) begin
                pc <= redirect ? decTarget : pc + 1'b1;
            end
            if (redirect || fetchStop) begin
                ifId <= '{pc: pc, instr: InstrBubble}; // squash the slot
            end else begin
                ifId <= '{pc: pc, instr: imemData};
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx    <= '0;
            exMem   <= '0;
            memWb   <= '0;
            numInst <= '0;
            halted  <= 1'b0;
        end else begin
            idEx.ctrl <= stall ? '0 : decCtrl;
            idEx.rs   <= decRs;
            idEx.rt   <= decRt;
            idEx.rd   <= decRd;
            idEx.opA  <= rdataA;
            idEx.opB  <= rdataB;
            idEx.imm  <= decImm;

            exMem <= '{ctrl: idEx.ctrl, rd: idEx.rd, aluRes: exResult, storeData: exStoreData};

            memWb.ctrl     <= exMem.ctrl;
            memWb.rd       <= exMem.rd;
            memWb.aluRes   <= exMem.aluRes;
            memWb.loadData <= dmemRData;
            if (exMem.ctrl.isWwd) begin
                memWb.wwdVal <= exMem.aluRes; // port keeps the last WWD value
            end

            // counted as it enters writeback
            if (exMem.ctrl.valid) begin
                numInst <= numInst + 1'b1;
            end
            if (exMem.ctrl.isHlt) begin
                halted <= 1'b1;
            end
        end
    end

    assign dmemAddr    = exMem.aluRes;
    assign dmemWData   = exMem.storeData;
    assign dmemWrite   = exMem.ctrl.memWrite;
    assign outputValid = memWb.ctrl.isWwd;
    assign outputPort  = memWb.wwdVal;

endmodule

/* hdl/cpu16Top.sv */
`timescale 1ns/1ns

module cpu16Top (
    input  logic            clk,
    input  logic            arstN,
    output cpu16Pkg::word_t imemAddr,
    output logic            imemRead,
    input  cpu16Pkg::word_t imemData,
    output cpu16Pkg::word_t outputPort,
    output logic            outputValid,
    output cpu16Pkg::word_t numInst,
    output logic            halted
);
    import cpu16Pkg::*;

    word_t dmemAddr;
    word_t dmemWData;
    word_t dmemRData;
    logic  dmemWrite;

    pipeDatapath pipeDatapath_inst (
        .clk, .arstN,
        .imemAddr, .imemRead, .imemData,
        .dmemAddr, .dmemWData, .dmemWrite, .dmemRData,
        .outputPort, .outputValid, .numInst, .halted
    );

    dataRam dataRam_inst (
        .clk, .addr(dmemAddr), .wdata(dmemWData), .wen(dmemWrite), .rdata(dmemRData)
    );

endmodule

/* sim/cpu16_sva.sv */
`timescale 1ns/1ns

module cpu16Sva (
    input logic            clk,
    input logic            arstN,
    input cpu16Pkg::word_t imemAddr,
    input logic            imemRead,
    input logic            outputValid,
    input cpu16Pkg::word_t numInst,
    input logic            halted
);

    // halt is sticky until the next reset
    haltSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
        else $error("halted fell while reset was inactive");

    instCountStep: assert property (@(posedge clk) disable iff (!arstN)
        (numInst == $past(numInst)) || (numInst == $past(numInst) + 16'd1))
        else $error("numInst changed by more than one in a cycle");

    noOutputAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !outputValid)
        else $error("outputValid seen while halted");

    // frozen fetch address
    fetchAddrHeld: assert property (@(posedge clk) disable iff (!arstN)
        !imemRead |=> $stable(imemAddr))
        else $error("imemAddr moved while imemRead was low");

endmodule

bind cpu16Top cpu16Sva cpu16Sva_inst (
    .clk, .arstN, .imemAddr, .imemRead, .outputValid, .numInst, .halted
);

/* sim/cpu16Tb.sv */
`timescale 1ns/1ns
`include "cpu16_cfg.svh"

module cpu16Tb;
    import cpu16Pkg::*;

    localparam int          HaltTimeout    = 2000;
    localparam int          ModelStepLimit = 1000;
    localparam int          ProgLen        = 40;
    localparam logic [31:0] RandSeed       = 32'hf55c_e040;
    localparam func_t       AluFns [4]     = '{FnAdd, FnSub, FnAnd, FnOrr};

    logic  clk;
    logic  arstN;
    word_t imemAddr;
    logic  imemRead;
    word_t imemData;
    word_t outputPort;
    logic  outputValid;
    word_t numInst;
    logic  halted;

    word_t instrMem [256];
    int    progLen;
    word_t gotOut [$];

    // architectural model
    word_t mRegs [`CPU16_NREG];
    word_t mMem [`CPU16_DMEM_DEPTH];
    word_t mPc;
    int    mCount;
    logic  mHalted;
    word_t expOut [$];
    int    storedAddrs [$]; // addresses a load may safely read

    int errors;
    int testsRun;
    int testsFailed;

    cpu16Top cpu16Top_inst (
        .clk, .arstN, .imemAddr, .imemRead, .imemData,
        .outputPort, .outputValid, .numInst, .halted
    );

    assign imemData = instrMem[imemAddr[7:0]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (arstN && outputValid) begin
            gotOut.push_back(outputPort);
        end
    end

    function automatic word_t rType(input int rs, input int rt, input int rd, input func_t fn);
        return {OpR, rs[1:0], rt[1:0], rd[1:0], fn};
    endfunction

    function automatic word_t iType(input opcode_t op, input int rs, input int rt,
                                    input int imm);
        return {op, rs[1:0], rt[1:0], imm[7:0]};
    endfunction

    function automatic word_t jType(input int target);
        return {OpJmp, target[11:0]};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = rType(0, 0, 0, FnHlt);
        end
        progLen = 0;
    endtask

    task automatic addInstr(input word_t instr);
        instrMem[progLen] = instr;
        progLen++;
    endtask

    task automatic checkEq(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("Error: %s expected %h, got %h", what, expVal, actVal);
            errors++;
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < `CPU16_NREG; i++) begin
            mRegs[i] = '0;
        end
        for (int i = 0; i < `CPU16_DMEM_DEPTH; i++) begin
            mMem[i] = '0;
        end
        mPc     = '0;
        mCount  = 0;
        mHalted = 1'b0;
        expOut.delete();
        storedAddrs.delete();
    endtask

    // steps one instruction in program order
    task automatic stepModel();
        word_t   ins;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        word_t   nextPc;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        int      idx;
        ins    = instrMem[mPc[7:0]];
        rs     = ins[11:10];
        rt     = ins[9:8];
        rd     = ins[7:6];
        a      = mRegs[rs];
        b      = mRegs[rt];
        imm    = {{8{ins[7]}}, ins[7:0]};
        addr   = a + imm;
        idx    = int'(addr) % `CPU16_DMEM_DEPTH; // wraps at the memory depth
        nextPc = mPc + 16'd1;
        mCount++;
        case (ins[15:12])
            OpR: begin
                case (ins[5:0])
                    FnAdd: mRegs[rd] = a + b;
                    FnSub: mRegs[rd] = a - b;
                    FnAnd: mRegs[rd] = a & b;
                    FnOrr: mRegs[rd] = a | b;
                    FnWwd: expOut.push_back(a);
                    FnHlt: mHalted = 1'b1;
                    default: ;
                endcase
            end
            OpAdi: mRegs[rt] = addr;
            OpLwd: mRegs[rt] = mMem[idx];
            OpSwd: begin
                mMem[idx] = b;
                storedAddrs.push_back(idx);
            end
            OpBeq: if (a == b) nextPc = mPc + 16'd1 + imm;
            OpBne: if (a != b) nextPc = mPc + 16'd1 + imm;
            OpJmp: nextPc = {mPc[15:12], ins[11:0]};
            default: ;
        endcase
        mPc = nextPc;
    endtask

    task automatic runModel();
        int steps;
        resetModel();
        steps = 0;
        while (!mHalted && steps < ModelStepLimit) begin
            stepModel();
            steps++;
        end
    endtask

    task automatic resetDut();
        @(negedge clk);
        arstN = 1'b0;
        repeat (5) @(negedge clk);
        gotOut.delete();
        arstN = 1'b1;
    endtask

    task automatic runTest(input string name);
        int cycles;
        int errBefore;
        errBefore = errors;
        runModel();
        resetDut();
        cycles = 0;
        while (!halted && cycles < HaltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: the processor did not halt within %0d cycles", name, HaltTimeout);
            errors++;
        end else begin
            checkEq({name, " numInst"}, mCount, 32'(numInst));
            repeat (20) @(negedge clk); // quiet window after halt
            checkEq({name, " numInst after halt"}, mCount, 32'(numInst));
            checkEq({name, " halted"}, 32'(mHalted), 32'(halted));
            checkEq({name, " imemRead"}, 32'd0, 32'(imemRead)); // fetch stays off after HLT
            checkEq({name, " wwd count"}, expOut.size(), gotOut.size());
            for (int i = 0; i < expOut.size() && i < gotOut.size(); i++) begin
                checkEq($sformatf("%s wwd[%0d]", name, i), 32'(expOut[i]), 32'(gotOut[i]));
            end
        end
        testsRun++;
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed", name);
        end
    endtask

    // the model steps along as slots are filled, so loads only hit stored words
    task automatic buildRandomProgram();
        int    kind;
        int    r1;
        int    r2;
        int    r3;
        int    span;
        int    addr;
        word_t instr;
        clearProgram();
        resetModel();
        for (int p = 0; p < ProgLen - 1; p++) begin
            kind = $urandom_range(0, 9);
            r1   = $urandom_range(0, 3);
            r2   = $urandom_range(0, 3);
            r3   = $urandom_range(0, 3);
            span = ProgLen - 2 - p; // farthest target is the HLT slot
            case (kind)
                0, 1: instr = rType(r1, r2, r3, AluFns[$urandom_range(0, 3)]);
                2: instr = iType(OpAdi, r1, r2, $urandom_range(0, 255));
                3: instr = iType(OpSwd, r1, r2, $urandom_range(0, 255));
                4: begin
                    if (storedAddrs.size() == 0) begin
                        instr = iType(OpAdi, r1, r2, $urandom_range(0, 255));
                    end else begin
                        addr  = storedAddrs[$urandom_range(0, storedAddrs.size() - 1)];
                        instr = iType(OpLwd, r1, r2, addr - int'(mRegs[r1]));
                    end
                end
                5: instr = iType($urandom_range(0, 1) ? OpBeq : OpBne, r1, r2,
                                 $urandom_range(0, span < 3 ? span : 3));
                6: instr = jType($urandom_range(p + 1, ProgLen - 1));
                default: instr = rType(r1, 0, 0, FnWwd);
            endcase
            instrMem[p] = instr;
            if (int'(mPc) == p) begin
                stepModel(); // slot lies on the executed path
            end
        end
        instrMem[ProgLen - 1] = rType(0, 0, 0, FnHlt);
    endtask

    initial begin
        arstN       = 1'b0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        clearProgram();
        void'($urandom(RandSeed));

        // dependent ALU chain
        addInstr(iType(OpAdi, 0, 1, 90));
        addInstr(iType(OpAdi, 1, 2, -35));
        addInstr(rType(1, 2, 3, FnAdd));
        addInstr(rType(3, 0, 0, FnWwd));
        addInstr(rType(3, 2, 1, FnSub));
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(rType(1, 3, 2, FnAnd));
        addInstr(rType(2, 0, 0, FnWwd));
        addInstr(rType(2, 1, 3, FnOrr));
        addInstr(rType(3, 0, 0, FnWwd));
        addInstr(iType(OpAdi, 3, 0, -100));
        addInstr(rType(0, 0, 0, FnWwd));
        addInstr(rType(0, 0, 0, FnHlt));
        runTest("aluForward");

        clearProgram();
        addInstr(iType(OpAdi, 0, 1, 55));
        addInstr(iType(OpAdi, 0, 2, 20));
        addInstr(iType(OpSwd, 2, 1, -3));
        addInstr(iType(OpLwd, 2, 3, -3));
        addInstr(rType(3, 1, 0, FnAdd)); // consumes the load right away
        addInstr(rType(0, 0, 0, FnWwd));
        addInstr(iType(OpLwd, 2, 1, -3));
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(rType(0, 0, 0, FnHlt));
        runTest("loadUse");

        clearProgram();
        addInstr(iType(OpAdi, 0, 1, 7));
        addInstr(iType(OpAdi, 0, 2, 7));
        addInstr(iType(OpBeq, 1, 2, 2));
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(rType(2, 0, 0, FnWwd));
        addInstr(iType(OpBne, 1, 2, 1));
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(iType(OpAdi, 0, 3, 1));
        addInstr(iType(OpBne, 3, 0, 1));
        addInstr(rType(3, 0, 0, FnWwd));
        addInstr(iType(OpBeq, 3, 0, 1));
        addInstr(rType(3, 0, 0, FnWwd));
        addInstr(jType(15));
        addInstr(rType(0, 0, 0, FnWwd));
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(rType(2, 0, 0, FnWwd));
        addInstr(rType(0, 0, 0, FnHlt));
        runTest("controlFlow");

        clearProgram();
        addInstr(iType(OpAdi, 0, 1, 85));
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(rType(0, 0, 0, FnHlt));
        addInstr(rType(1, 0, 0, FnWwd)); // must never retire
        addInstr(rType(1, 0, 0, FnWwd));
        addInstr(iType(OpAdi, 1, 1, 1));
        runTest("halt");

        for (int i = 0; i < 10; i++) begin
            buildRandomProgram();
            runTest($sformatf("random%0d", i));
        end

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* cpu16.f */
+incdir+hdl
hdl/cpu16Pkg.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/dataRam.sv
hdl/pipeDatapath.sv
hdl/cpu16Top.sv
sim/cpu16_sva.sv
sim/cpu16Tb.sv

/* Makefile */
# Verilator build and run for cpu16

TOP       ?= cpu16Tb
SEED      ?= 0
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FLIST     ?= cpu16.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP=$(TOP) SEED=$(SEED) LOG=$(LOG) VERILATOR=$(VERILATOR)"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	    -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF ">>> FAIL" $(LOG) || ! grep -qF ">>> PASS" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
